// File: ifu_pkg.sv
package ifu_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [3:0]  index_t;
    typedef logic [1:0]  offset_t;
    typedef logic [23:0] tag_t;
    typedef logic [7:0]  len_t;

    localparam addr_t RESET_PC = 32'h8000_0000;

    localparam int LINE_WORDS = 4;
    localparam int NUM_LINES  = 16;

    // burst length is sent as beats minus one.
    localparam len_t BURST_LEN = 8'd3;

    // FENCE.I shares the MISC-MEM opcode with FENCE and sets funct3 bit 0.
    localparam logic [6:0] OPC_FENCE   = 7'b0001111;
    localparam int         FENCE_I_BIT = 12;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_LOOKUP,
        FETCH_HOLD
    } fetch_state_e;

    typedef enum logic [1:0] {
        REFILL_IDLE,
        REFILL_REQ,
        REFILL_BEAT
    } refill_state_e;

    function automatic offset_t addr_offset(input addr_t addr);
        return addr[3:2];
    endfunction

    function automatic index_t addr_index(input addr_t addr);
        return addr[7:4];
    endfunction

    function automatic tag_t addr_tag(input addr_t addr);
        return addr[31:8];
    endfunction

endpackage

// File: icache_if.sv
`timescale 1ns/1ps

interface icache_if import ifu_pkg::*; ();

    logic  req;
    addr_t addr;
    logic  fence;
    logic  ready;
    inst_t data;

    modport requester (
        output req,
        output addr,
        output fence,
        input  ready,
        input  data
    );

    modport responder (
        input  req,
        input  addr,
        input  fence,
        output ready,
        output data
    );

endinterface

// File: refill_if.sv
`timescale 1ns/1ps

interface refill_if import ifu_pkg::*; ();

    logic    start;
    addr_t   line_addr;
    logic    beat_valid;
    offset_t beat_idx;
    inst_t   beat_data;
    logic    done;

    modport array (
        output start,
        output line_addr,
        input  beat_valid,
        input  beat_idx,
        input  beat_data,
        input  done
    );

    modport engine (
        input  start,
        input  line_addr,
        output beat_valid,
        output beat_idx,
        output beat_data,
        output done
    );

endinterface

// File: pc_gen.sv
`timescale 1ns/1ps

module pc_gen import ifu_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  advance_i,
    input  logic  jump_valid_i,
    input  addr_t jump_pc_i,
    output addr_t pc_o
);

    addr_t pc_q;
    addr_t pc_next;

    // a redirect only counts in the cycle an instruction is delivered.
    always_comb begin
        pc_next = pc_q;
        if (advance_i) begin
            if (jump_valid_i) begin
                pc_next = jump_pc_i;
            end else begin
                pc_next = pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // the fetch address stays word aligned.
    assert property (@(posedge clock) disable iff (reset)
        advance_i |=> pc_o[1:0] == 2'b00);

endmodule

// File: fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl import ifu_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        stall_i,
    input  addr_t       pc_i,
    output logic        advance_o,
    icache_if.requester cache,
    output logic        ifu_stall_o,
    output addr_t       pc_o,
    output inst_t       inst_o
);

    fetch_state_e state_q;
    logic         req_q;
    logic         fence_q;
    logic         fence_arm_q;
    logic         stall_q;
    logic         present_q;
    logic         outstanding_q;
    inst_t        hold_q;
    addr_t        pc_q;
    inst_t        inst_q;

    logic         load;
    inst_t        load_word;
    logic         issue;

    function automatic logic is_fence_i(input inst_t word);
        return (word[6:0] == OPC_FENCE) && word[FENCE_I_BIT];
    endfunction

    // the word on the output is delivered once the pipeline is not stalled.
    assign advance_o = present_q & ~stall_i;

    // the output takes the cache answer directly, or the buffered word after a stall.
    assign load = ((state_q == FETCH_LOOKUP) & cache.ready & ~stall_i) |
                  ((state_q == FETCH_HOLD) & ~stall_i);
    assign load_word = (state_q == FETCH_HOLD) ? hold_q : cache.data;

    // no lookup while a presented word waits, or before a pending fence has gone out.
    assign issue = (state_q == FETCH_IDLE) & (advance_o | ~present_q) & ~fence_arm_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q     <= FETCH_IDLE;
            req_q       <= 1'b0;
            fence_q     <= 1'b0;
            fence_arm_q <= 1'b0;
            stall_q     <= 1'b0;
            present_q   <= 1'b0;
        end else begin
            req_q       <= issue;
            fence_q     <= fence_arm_q;
            fence_arm_q <= load & is_fence_i(load_word);

            case (state_q)
                FETCH_IDLE: begin
                    if (issue) begin
                        state_q <= FETCH_LOOKUP;
                    end
                end
                FETCH_LOOKUP: begin
                    if (cache.ready) begin
                        state_q <= stall_i ? FETCH_HOLD : FETCH_IDLE;
                    end
                end
                FETCH_HOLD: begin
                    if (!stall_i) begin
                        state_q <= FETCH_IDLE;
                    end
                end
                default: state_q <= FETCH_IDLE;
            endcase

            if (load) begin
                present_q <= 1'b1;
                stall_q   <= 1'b0;
            end else if (advance_o || issue) begin
                present_q <= 1'b0;
                stall_q   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if ((state_q == FETCH_LOOKUP) && cache.ready) begin
            hold_q <= cache.data;
        end
        // pc_i only moves on delivery, so it still names the word being loaded.
        if (load) begin
            pc_q   <= pc_i;
            inst_q <= load_word;
        end
    end

    // a lookup is open from its req until the matching ready.
    always_ff @(posedge clock) begin
        if (reset) begin
            outstanding_q <= 1'b0;
        end else if (cache.req) begin
            outstanding_q <= 1'b1;
        end else if (cache.ready) begin
            outstanding_q <= 1'b0;
        end
    end

    assign cache.req   = req_q;
    assign cache.addr  = pc_i;
    assign cache.fence = fence_q;

    assign ifu_stall_o = stall_q;
    assign pc_o        = pc_q;
    assign inst_o      = inst_q;

    // the cache answers only an open lookup, and no lookup is issued before that answer.
    assert property (@(posedge clock) disable iff (reset)
        cache.ready |-> state_q == FETCH_LOOKUP);
    assert property (@(posedge clock) disable iff (reset)
        cache.req |-> !outstanding_q);

endmodule

// File: icache_array.sv
`timescale 1ns/1ps

module icache_array import ifu_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    icache_if.responder cache,
    refill_if.array     refill
);

    logic [NUM_LINES-1:0] valid_q;
    tag_t                 tag_mem  [NUM_LINES];
    inst_t                data_mem [NUM_LINES][LINE_WORDS];

    addr_t   lookup_addr_q;
    logic    busy_q;
    logic    ready_q;
    logic    start_q;
    inst_t   rdata_q;

    index_t  req_index;
    logic    hit;
    logic    miss;
    index_t  fill_index;
    offset_t fill_offset;

    assign req_index   = addr_index(cache.addr);
    assign hit         = valid_q[req_index] && (tag_mem[req_index] == addr_tag(cache.addr));
    assign miss        = cache.req && !hit;
    assign fill_index  = addr_index(lookup_addr_q);
    assign fill_offset = addr_offset(lookup_addr_q);

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            busy_q  <= 1'b0;
            ready_q <= 1'b0;
            start_q <= 1'b0;
        end else begin
            // a miss is answered right after the line has been filled.
            ready_q <= (cache.req && hit) || refill.done;
            start_q <= miss;
            if (miss) begin
                busy_q <= 1'b1;
            end else if (refill.done) begin
                busy_q <= 1'b0;
            end
            if (cache.fence) begin
                valid_q <= '0;
            end else if (refill.done) begin
                valid_q[fill_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (cache.req) begin
            lookup_addr_q <= cache.addr;
        end
        if (cache.req && hit) begin
            rdata_q <= data_mem[req_index][addr_offset(cache.addr)];
        end else if (refill.done) begin
            rdata_q <= data_mem[fill_index][fill_offset];
        end
        if (refill.beat_valid) begin
            data_mem[fill_index][refill.beat_idx] <= refill.beat_data;
        end
        if (refill.done) begin
            tag_mem[fill_index] <= addr_tag(lookup_addr_q);
        end
    end

    assign cache.ready      = ready_q;
    assign cache.data       = rdata_q;
    assign refill.start     = start_q;
    assign refill.line_addr = {addr_tag(lookup_addr_q), fill_index, 4'b0000};

    // fetch control has to wait for the answer, so nothing looks up into a half-filled line.
    assert property (@(posedge clock) disable iff (reset)
        busy_q |-> !cache.req);

endmodule

// File: icache_refill.sv
`timescale 1ns/1ps

module icache_refill import ifu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    refill_if.engine   refill,
    output logic       mem_r_valid_o,
    output addr_t      mem_r_addr_o,
    output len_t       mem_r_len_o,
    input  logic       mem_r_ready_i,
    input  inst_t      mem_r_data_i,
    input  logic       mem_r_last_i
);

    refill_state_e state_q;
    offset_t       beat_cnt_q;
    addr_t         line_addr_q;
    logic          done_q;
    logic          beat;

    assign beat = (state_q != REFILL_IDLE) && mem_r_ready_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q    <= REFILL_IDLE;
            beat_cnt_q <= '0;
            done_q     <= 1'b0;
        end else begin
            // done follows the cycle in which the last beat is written.
            done_q <= beat && mem_r_last_i;
            case (state_q)
                REFILL_IDLE: begin
                    if (refill.start) begin
                        state_q    <= REFILL_REQ;
                        beat_cnt_q <= '0;
                    end
                end
                REFILL_REQ, REFILL_BEAT: begin
                    if (mem_r_ready_i) begin
                        beat_cnt_q <= beat_cnt_q + 2'd1;
                        state_q    <= mem_r_last_i ? REFILL_IDLE : REFILL_BEAT;
                    end
                end
                default: state_q <= REFILL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if ((state_q == REFILL_IDLE) && refill.start) begin
            line_addr_q <= refill.line_addr;
        end
    end

    // the request stays up until the cycle after the last beat.
    assign mem_r_valid_o = (state_q != REFILL_IDLE);
    assign mem_r_addr_o  = line_addr_q;
    assign mem_r_len_o   = BURST_LEN;

    assign refill.beat_valid = beat;
    assign refill.beat_idx   = beat_cnt_q;
    assign refill.beat_data  = mem_r_data_i;
    assign refill.done       = done_q;

    // memory must end the burst on exactly the fourth beat.
    assert property (@(posedge clock) disable iff (reset)
        beat |-> (mem_r_last_i == (beat_cnt_q == offset_t'(LINE_WORDS - 1))));

endmodule

// File: ifu_top.sv
`timescale 1ns/1ps

module ifu_top import ifu_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  stall_i,
    input  logic  jump_valid_i,
    input  addr_t jump_pc_i,
    output logic  ifu_stall_o,
    output addr_t pc_o,
    output inst_t inst_o,
    output logic  mem_r_valid_o,
    output addr_t mem_r_addr_o,
    output len_t  mem_r_len_o,
    input  logic  mem_r_ready_i,
    input  inst_t mem_r_data_i,
    input  logic  mem_r_last_i
);

    icache_if cache_bus ();
    refill_if refill_bus ();

    addr_t fetch_pc;
    logic  advance;

    pc_gen u_pc_gen (
        .clock        (clock),
        .reset        (reset),
        .advance_i    (advance),
        .jump_valid_i (jump_valid_i),
        .jump_pc_i    (jump_pc_i),
        .pc_o         (fetch_pc)
    );

    fetch_ctrl u_fetch_ctrl (
        .clock       (clock),
        .reset       (reset),
        .stall_i     (stall_i),
        .pc_i        (fetch_pc),
        .advance_o   (advance),
        .cache       (cache_bus.requester),
        .ifu_stall_o (ifu_stall_o),
        .pc_o        (pc_o),
        .inst_o      (inst_o)
    );

    icache_array u_icache_array (
        .clock  (clock),
        .reset  (reset),
        .cache  (cache_bus.responder),
        .refill (refill_bus.array)
    );

    icache_refill u_icache_refill (
        .clock         (clock),
        .reset         (reset),
        .refill        (refill_bus.engine),
        .mem_r_valid_o (mem_r_valid_o),
        .mem_r_addr_o  (mem_r_addr_o),
        .mem_r_len_o   (mem_r_len_o),
        .mem_r_ready_i (mem_r_ready_i),
        .mem_r_data_i  (mem_r_data_i),
        .mem_r_last_i  (mem_r_last_i)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock_o,
    output logic reset_o
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 4;

    initial begin
        clock_o = 1'b0;
        forever #HALF_PERIOD clock_o = ~clock_o;
    end

    // reset is released on a falling edge, half a cycle away from the sampling edge.
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_o);
        @(negedge clock_o);
        reset_o = 1'b0;
    end

endmodule

// File: tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model import ifu_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  mem_r_valid_i,
    input  addr_t mem_r_addr_i,
    input  len_t  mem_r_len_i,
    output logic  mem_r_ready_o,
    output inst_t mem_r_data_o,
    output logic  mem_r_last_o,
    input  logic  wr_en_i,
    input  addr_t wr_addr_i,
    input  inst_t wr_data_i,
    output int    burst_count_o
);

    localparam inst_t FILL_MASK = 32'h5a5a_0000;

    inst_t  store [addr_t];
    logic   ready_q  = 1'b0;
    logic   last_q   = 1'b0;
    inst_t  data_q   = '0;
    int     bursts   = 0;
    logic   active   = 1'b0;
    integer gap_seed = 32'h1c8a3089;
    addr_t  base;
    int     beat;
    int     last_beat;
    int     gap;

    // words that were never written return a pattern of their own address.
    function automatic inst_t read_word(input addr_t addr);
        if (store.exists(addr)) begin
            return store[addr];
        end
        return addr ^ FILL_MASK;
    endfunction

    always @(posedge clock) begin
        if (wr_en_i) begin
            store[wr_addr_i] = wr_data_i;
        end
    end

    // beats change on the falling edge, like every other DUT input.
    always @(negedge clock) begin
        ready_q = 1'b0;
        last_q  = 1'b0;
        if (reset) begin
            active = 1'b0;
        end else begin
            if (!active && mem_r_valid_i) begin
                active    = 1'b1;
                base      = mem_r_addr_i;
                last_beat = int'(mem_r_len_i);
                beat      = 0;
                gap       = {$random(gap_seed)} % 3;
                bursts    = bursts + 1;
            end
            if (active) begin
                if (gap > 0) begin
                    gap = gap - 1;
                end else begin
                    ready_q = 1'b1;
                    data_q  = read_word(base + addr_t'(4 * beat));
                    last_q  = (beat == last_beat);
                    if (beat == last_beat) begin
                        active = 1'b0;
                    end else begin
                        beat = beat + 1;
                        gap  = {$random(gap_seed)} % 3;
                    end
                end
            end
        end
    end

    assign mem_r_ready_o = ready_q;
    assign mem_r_data_o  = data_q;
    assign mem_r_last_o  = last_q;
    assign burst_count_o = bursts;

endmodule

// File: tb_ifu.sv
`timescale 1ns/1ps

module tb_ifu import ifu_pkg::*; ();

    localparam int    WAIT_LIMIT    = 100;
    localparam addr_t JUMP_PC       = 32'h8000_0400;
    localparam addr_t FENCE_PC      = 32'h8000_0840;
    localparam inst_t FENCE_I_WORD  = 32'h0000_100f;
    localparam inst_t NEW_WORD_BASE = 32'h1357_9b00;
    localparam inst_t FILL_MASK     = 32'h5a5a_0000;

    logic  clock;
    logic  reset;
    logic  stall;
    logic  jump_valid;
    addr_t jump_pc;
    logic  ifu_stall;
    addr_t fetch_pc;
    inst_t fetch_inst;
    logic  mem_r_valid;
    addr_t mem_r_addr;
    len_t  mem_r_len;
    logic  mem_r_ready;
    inst_t mem_r_data;
    logic  mem_r_last;
    logic  wr_en;
    addr_t wr_addr;
    inst_t wr_data;
    int    burst_count;

    int     error_count = 0;
    int     check_count = 0;
    int     test_count  = 0;
    addr_t  exp_pc      = RESET_PC;
    integer stall_seed  = 32'h1c8a3089;
    inst_t  written [addr_t];

    tb_clock_gen u_clock (
        .clock_o (clock),
        .reset_o (reset)
    );

    tb_mem_model u_mem (
        .clock         (clock),
        .reset         (reset),
        .mem_r_valid_i (mem_r_valid),
        .mem_r_addr_i  (mem_r_addr),
        .mem_r_len_i   (mem_r_len),
        .mem_r_ready_o (mem_r_ready),
        .mem_r_data_o  (mem_r_data),
        .mem_r_last_o  (mem_r_last),
        .wr_en_i       (wr_en),
        .wr_addr_i     (wr_addr),
        .wr_data_i     (wr_data),
        .burst_count_o (burst_count)
    );

    ifu_top DUT (
        .clock         (clock),
        .reset         (reset),
        .stall_i       (stall),
        .jump_valid_i  (jump_valid),
        .jump_pc_i     (jump_pc),
        .ifu_stall_o   (ifu_stall),
        .pc_o          (fetch_pc),
        .inst_o        (fetch_inst),
        .mem_r_valid_o (mem_r_valid),
        .mem_r_addr_o  (mem_r_addr),
        .mem_r_len_o   (mem_r_len),
        .mem_r_ready_i (mem_r_ready),
        .mem_r_data_i  (mem_r_data),
        .mem_r_last_i  (mem_r_last)
    );

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic abort_wait(input string what);
        error_count++;
        $display("Timeout while waiting for %s after %0d cycles", what, WAIT_LIMIT);
        $display("Test failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endtask

    function automatic inst_t expected_word(input addr_t addr);
        if (written.exists(addr)) begin
            return written[addr];
        end
        return addr ^ FILL_MASK;
    endfunction

    task automatic write_word(input addr_t addr, input inst_t data);
        @(negedge clock);
        wr_en         = 1'b1;
        wr_addr       = addr;
        wr_data       = data;
        written[addr] = data;
        @(negedge clock);
        wr_en = 1'b0;
    endtask

    // waits for a presented word, lets it go and checks it against the next expected pc.
    task automatic fetch_one(input logic do_jump, input addr_t target);
        int    cycles;
        bit    found;
        addr_t got_pc;
        inst_t got_inst;
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            stall      = 1'b0;
            jump_valid = do_jump;
            jump_pc    = target;
            // a refill in flight reads the line of the pc still to be delivered.
            if (mem_r_valid) begin
                check_value("burst address", mem_r_addr, {exp_pc[31:4], 4'b0000});
                check_value("burst length", 32'(mem_r_len), 32'(LINE_WORDS - 1));
            end
            if (!ifu_stall) begin
                found    = 1'b1;
                got_pc   = fetch_pc;
                got_inst = fetch_inst;
            end
            cycles++;
        end
        if (!found) begin
            abort_wait("a delivered instruction");
        end
        check_value("delivered pc", got_pc, exp_pc);
        check_value("delivered word", got_inst, expected_word(exp_pc));
        exp_pc = do_jump ? target : exp_pc + 32'd4;
        // the pipeline stays stalled between deliveries.
        @(negedge clock);
        stall      = 1'b1;
        jump_valid = 1'b0;
    endtask

    // keeps stall_i high and checks that the outputs do not move.
    task automatic hold_and_check(input int cycles, input logic exp_busy);
        addr_t held_pc;
        inst_t held_inst;
        held_pc   = fetch_pc;
        held_inst = fetch_inst;
        repeat (cycles) begin
            @(negedge clock);
            stall = 1'b1;
            check_value("pc_o during stall", fetch_pc, held_pc);
            check_value("inst_o during stall", fetch_inst, held_inst);
            check_value("ifu_stall_o during stall", 32'(ifu_stall), 32'(exp_busy));
        end
    endtask

    task automatic test_reset();
        int errors_before;
        int cycles;
        bit seen;
        errors_before = error_count;
        repeat (3) begin
            @(negedge clock);
            check_value("mem_r_valid_o in reset", 32'(mem_r_valid), 32'd0);
            check_value("ifu_stall_o in reset", 32'(ifu_stall), 32'd0);
        end
        cycles = 0;
        while (reset && cycles < WAIT_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        if (reset) begin
            abort_wait("reset release");
        end
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            seen = ifu_stall;
            cycles++;
        end
        if (!seen) begin
            abort_wait("ifu_stall_o after reset");
        end
        exp_pc = RESET_PC;
        fetch_one(1'b0, '0);
        report_test("reset", errors_before);
    endtask

    task automatic test_sequential();
        int errors_before;
        int bursts_before;
        errors_before = error_count;
        bursts_before = burst_count;
        repeat (12) fetch_one(1'b0, '0);
        check_value("bursts over three new lines", burst_count, bursts_before + 3);
        report_test("sequential fetch", errors_before);
    endtask

    task automatic test_hits();
        int errors_before;
        int bursts_before;
        errors_before = error_count;
        bursts_before = burst_count;
        fetch_one(1'b1, RESET_PC);
        repeat (12) fetch_one(1'b0, '0);
        check_value("bursts on cached lines", burst_count, bursts_before);
        report_test("cache hits", errors_before);
    endtask

    task automatic test_redirect();
        int errors_before;
        errors_before = error_count;
        fetch_one(1'b1, JUMP_PC);
        repeat (4) fetch_one(1'b0, '0);
        report_test("redirect", errors_before);
    endtask

    task automatic test_stall();
        int errors_before;
        int stall_cycles;
        int cycles;
        bit found;
        errors_before = error_count;
        stall_cycles  = 5 + ({$random(stall_seed)} % 16);
        cycles        = 0;
        found         = 1'b0;
        // the stall goes up in the cycle a new word is presented.
        while (!found && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            if (!ifu_stall) begin
                found = 1'b1;
                stall = 1'b1;
            end else begin
                stall = 1'b0;
            end
            cycles++;
        end
        if (!found) begin
            abort_wait("a presented word");
        end
        check_value("presented pc", fetch_pc, exp_pc);
        hold_and_check(stall_cycles, 1'b0);
        repeat (2) fetch_one(1'b0, '0);
        // the next word comes back while stalled and waits in the buffer.
        hold_and_check(stall_cycles, 1'b1);
        repeat (2) fetch_one(1'b0, '0);
        report_test("stall", errors_before);
    endtask

    task automatic test_fence();
        int errors_before;
        int bursts_before;
        errors_before = error_count;
        write_word(FENCE_PC, FENCE_I_WORD);
        fetch_one(1'b1, RESET_PC);
        // this caches the first line with its old words.
        fetch_one(1'b1, FENCE_PC);
        for (int i = 0; i < LINE_WORDS; i++) begin
            write_word(RESET_PC + addr_t'(4 * i), NEW_WORD_BASE + inst_t'(i));
        end
        fetch_one(1'b1, RESET_PC);
        bursts_before = burst_count;
        fetch_one(1'b0, '0);
        check_value("bursts after FENCE.I", burst_count, bursts_before + 1);
        repeat (3) fetch_one(1'b0, '0);
        report_test("fence.i", errors_before);
    endtask

    initial begin
        stall      = 1'b1;
        jump_valid = 1'b0;
        jump_pc    = '0;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        test_reset();
        test_sequential();
        test_hits();
        test_redirect();
        test_stall();
        test_fence();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: build.f
ifu_pkg.sv
icache_if.sv
refill_if.sv
pc_gen.sv
fetch_ctrl.sv
icache_array.sv
icache_refill.sv
ifu_top.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_ifu.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_ifu
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Test failed" >> $(LOG)
	@cat $(LOG)
	@! grep -q "Test failed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
